// File: files.f
+incdir+include
rtl/renkon_num_pkg.sv
rtl/renkon_ctrl_pkg.sv
rtl/conv_tree25.sv
rtl/weight_bank.sv
rtl/window_buffer.sv
rtl/conv_ctrl.sv
rtl/conv_layer.sv
tests/tb_conv_layer.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_conv_layer
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tests/tb_conv_layer.sv
module tb_conv_layer
  import renkon_num_pkg::*;
  import renkon_ctrl_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMG_W = 8;
  localparam int IMG_H = 8;
  localparam int NOUT  = (IMG_H - 4) * (IMG_W - 4);
  localparam int NCASE = 7;

  typedef enum logic [1:0] {W_IDENT, W_RAND, W_SIGNS, W_SAME} wkind_e;
  typedef enum logic [0:0] {I_RAND, I_SAME} ikind_e;

  typedef struct packed {
    logic [8*10-1:0] name;
    wkind_e          wkind;
    data_t           bias;
    ikind_e          ikind;
    logic [1:0]      gap;
  } case_t;

  // ********************
  // test table
  // ********************
  localparam case_t CASES [NCASE] = '{
    '{"identity  ", W_IDENT, 16'sd0,     I_RAND, 2'd0},
    '{"random    ", W_RAND,  16'sd0,     I_RAND, 2'd0},
    '{"sign_round", W_SIGNS, 16'sd0,     I_RAND, 2'd2},
    '{"neg_bias  ", W_IDENT, -16'sd2048, I_RAND, 2'd0},
    '{"pos_bias  ", W_RAND,  16'sd300,   I_RAND, 2'd0},
    '{"gap1_same ", W_SAME,  16'sd300,   I_SAME, 2'd1},  // same data as pos_bias.
    '{"gap3_same ", W_SAME,  16'sd300,   I_SAME, 2'd3}
  };

  logic  clk;
  logic  xrst;
  logic  start;
  logic  pix_valid;
  data_t pixel;
  wr_t   wr;
  logic  busy;
  fmap_t fmap;

  data_t img [IMG_H][IMG_W];
  data_t wgt [KTAPS];
  data_t exp_data [$];
  bit    exp_last [$];
  int    exp_cyc [$];
  int    cyc = 0;
  logic  start_q = 1'b0;
  logic  last_q = 1'b0;
  int    errors = 0;
  int    n_out = 0;
  int    total_out = 0;
  int    round_hits = 0;
  bit    timed_out = 1'b0;

  conv_layer #(
    .IMG_WIDTH  (IMG_W),
    .IMG_HEIGHT (IMG_H)
  ) i_conv_layer (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .pix_valid (pix_valid),
    .pixel     (pixel),
    .wr        (wr),
    .busy      (busy),
    .fmap      (fmap)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("Error: %0t ns %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // bits FRAC up to the top kept bit, exact negatives drop one lsb.
  function automatic data_t narrow_product(input int prod);
    logic [31:0] p;
    int          v;
    p = prod;
    v = int'($signed(p[2*DWIDTH-FRAC-2:FRAC]));
    if (p[2*DWIDTH-FRAC-2] && p[FRAC-1:0] == '0) begin
      v = v - 1;
    end
    return data_t'(v);
  endfunction

  task automatic build_expected(input data_t bias);
    int          acc;
    int          prod;
    logic [31:0] pb;
    data_t       res;
    for (int y = 4; y < IMG_H; y++) begin
      for (int x = 4; x < IMG_W; x++) begin
        acc = 0;
        for (int t = 0; t < KTAPS; t++) begin
          prod = int'(img[y-4+t/KSIZE][x-4+t%KSIZE]) * int'(wgt[t]);
          pb   = prod;
          if (pb[2*DWIDTH-FRAC-2] && pb[FRAC-1:0] == '0) round_hits++;
          acc = acc + int'(narrow_product(prod));
        end
        res = data_t'(acc + int'(bias));
        if (res < 0) res = '0;  // relu.
        exp_data.push_back(res);
        exp_last.push_back(y == IMG_H - 1 && x == IMG_W - 1);
      end
    end
  endtask

  task automatic run_case(input int i);
    case_t c;
    c = CASES[i];
    for (int t = 0; t < KTAPS; t++) begin
      case (c.wkind)
        W_IDENT: wgt[t] = (t == KTAPS / 2) ? 16'sd256 : 16'sd0;  // 1.0 at centre.
        W_RAND:  wgt[t] = data_t'(int'($urandom_range(127)) - 64);
        W_SIGNS: wgt[t] = ($urandom_range(1) == 1) ? 16'sd256 : -16'sd256;
        default: ;
      endcase
    end
    if (c.ikind == I_RAND) begin
      for (int y = 0; y < IMG_H; y++) begin
        for (int x = 0; x < IMG_W; x++) begin
          img[y][x] = data_t'(int'($urandom_range(2047)) - 1024);
        end
      end
    end
    build_expected(c.bias);
    for (int a = 0; a <= KTAPS; a++) begin
      @(posedge clk);
      wr <= '{we: 1'b1, addr: AWIDTH'(a), data: (a < KTAPS) ? wgt[a] : c.bias};
    end
    @(posedge clk);
    wr    <= '0;
    n_out  = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    for (int y = 0; y < IMG_H; y++) begin
      for (int x = 0; x < IMG_W; x++) begin
        @(posedge clk);
        pix_valid <= 1'b1;
        pixel     <= img[y][x];
        if (y >= 4 && x >= 4) exp_cyc.push_back(cyc + 8);  // strobe cycle plus 7.
        repeat (c.gap) begin
          @(posedge clk);
          pix_valid <= 1'b0;
        end
      end
    end
    @(posedge clk);
    pix_valid <= 1'b0;
    for (int n = 0; n <= 50; n++) begin
      @(posedge clk);
      if (!busy) break;
      if (n == 50) begin
        $display("Timeout: busy never fell after case %s", c.name);
        timed_out = 1'b1;
        return;
      end
    end
    @(posedge clk);
    if (n_out != NOUT || exp_data.size() != 0) begin
      errors++;
      $display("Case %s gave %0d outputs instead of %0d", c.name, n_out, NOUT);
    end
    exp_data.delete();
    exp_last.delete();
    exp_cyc.delete();
  endtask

  // ********************
  // output monitor
  // ********************
  initial begin
    forever begin
      @(posedge clk);
      cyc     <= cyc + 1;
      start_q <= start;
      last_q  <= fmap.valid && fmap.last;
      if (xrst) begin
        if (start_q) check_value("busy", int'(busy), 1);  // rises after start.
        if (last_q) check_value("busy", int'(busy), 0);   // falls after last.
        if (fmap.valid) begin
          n_out++;
          total_out++;
          check_value("busy", int'(busy), 1);
          if (exp_data.size() == 0) begin
            errors++;
            $display("Output at %0t ns arrived with nothing expected", $time);
          end else begin
            check_value("fmap.data", int'($signed(fmap.data)), int'(exp_data.pop_front()));
            check_value("fmap.last", int'(fmap.last), int'(exp_last.pop_front()));
          end
          if (exp_cyc.size() != 0) check_value("valid cycle", cyc, exp_cyc.pop_front());
        end else begin
          check_value("fmap.last", int'(fmap.last), 0);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h0a829985));
    xrst      <= 1'b0;
    start     <= 1'b0;
    pix_valid <= 1'b0;
    pixel     <= '0;
    wr        <= '0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
    @(posedge clk);
    check_value("fmap.valid", int'(fmap.valid), 0);
    check_value("fmap.last", int'(fmap.last), 0);
    check_value("busy", int'(busy), 0);
    for (int i = 0; i < NCASE; i++) begin
      run_case(i);
      if (timed_out) break;
    end
    if (!timed_out && round_hits == 0) begin
      errors++;
      $display("Rounding case with a zero fraction was never exercised");
    end
    $display("Done: %0d errors, %0d outputs checked", errors, total_out);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: rtl/conv_layer.sv
module conv_layer
  import renkon_num_pkg::*;
  import renkon_ctrl_pkg::*;
#(
  parameter int IMG_WIDTH  = 8,
  parameter int IMG_HEIGHT = 8
) (
  input  logic  clk,
  input  logic  xrst,
  input  logic  start,
  input  logic  pix_valid,
  input  data_t pixel,
  input  wr_t   wr,
  output logic  busy,
  output fmap_t fmap
);

  window_t weights;
  window_t window;
  data_t   bias;
  data_t   tree_sum;

  weight_bank i_weight_bank (
    .clk     (clk),
    .xrst    (xrst),
    .wr      (wr),
    .weights (weights),
    .bias    (bias)
  );

  window_buffer #(
    .IMG_WIDTH (IMG_WIDTH)
  ) i_window_buffer (
    .clk       (clk),
    .xrst      (xrst),
    .pix_valid (pix_valid),
    .pixel     (pixel),
    .window    (window)
  );

  conv_tree25 i_conv_tree25 (
    .clk    (clk),
    .xrst   (xrst),
    .pixel  (window),
    .weight (weights),
    .fmap   (tree_sum)
  );

  conv_ctrl #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT)
  ) i_conv_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .pix_valid (pix_valid),
    .tree_sum  (tree_sum),
    .bias      (bias),
    .wr_we     (wr.we),
    .busy      (busy),
    .fmap      (fmap)
  );

endmodule

// File: rtl/conv_ctrl.sv
module conv_ctrl
  import renkon_num_pkg::*;
  import renkon_ctrl_pkg::*;
#(
  parameter int IMG_WIDTH  = 8,
  parameter int IMG_HEIGHT = 8
) (
  input  logic  clk,
  input  logic  xrst,
  input  logic  start,
  input  logic  pix_valid,
  input  data_t tree_sum,
  input  data_t bias,
  input  logic  wr_we,
  output logic  busy,
  output fmap_t fmap
);

  localparam int CW  = $clog2(IMG_WIDTH);
  localparam int RW  = $clog2(IMG_HEIGHT);
  localparam int DLY = 6;  // window register plus tree.

  conv_state_e      state;
  logic [CW-1:0]    col;
  logic [RW-1:0]    row;
  logic             row_end;
  logic             last_pix;
  logic             win_ok;
  logic [DLY-1:0]   v_pipe;
  logic [DLY-1:0]   l_pipe;
  data_t            sum_b;
  data_t            relu;
  fmap_t            r_fmap;

  assign row_end  = pix_valid && col == CW'(IMG_WIDTH - 1);
  assign last_pix = row_end && row == RW'(IMG_HEIGHT - 1);
  assign win_ok   = pix_valid && row >= RW'(KSIZE - 1) && col >= CW'(KSIZE - 1);

  // ********************
  // counters and FSM
  // ********************
  always_ff @(posedge clk) begin
    if (!xrst || start) begin
      col <= '0;
      row <= '0;
    end else if (pix_valid) begin
      col <= row_end ? '0 : col + 1'b1;
      if (row_end) begin
        row <= last_pix ? '0 : row + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (start) state <= S_FILL;
        S_FILL: if (row_end && row == RW'(KSIZE - 2)) state <= S_RUN;
        S_RUN:  if (last_pix) state <= S_DONE;
        S_DONE: if (r_fmap.last) state <= S_IDLE;  // busy drops next cycle.
        default: state <= S_IDLE;
      endcase
    end
  end

  assign busy = state != S_IDLE;

  // valid and last follow the pixel through the datapath.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      v_pipe <= '0;
      l_pipe <= '0;
    end else begin
      v_pipe <= {v_pipe[DLY-2:0], win_ok};
      l_pipe <= {l_pipe[DLY-2:0], last_pix};
    end
  end

  // ********************
  // bias and relu
  // ********************
  assign sum_b = tree_sum + bias;
  assign relu  = sum_b[DWIDTH-1] ? '0 : sum_b;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fmap <= '0;
    end else begin
      r_fmap.valid <= v_pipe[DLY-1];
      r_fmap.last  <= l_pipe[DLY-1];
      if (v_pipe[DLY-1]) begin
        r_fmap.data <= relu;
      end
    end
  end

  assign fmap = r_fmap;

  a_no_pix_idle: assert property (
    @(posedge clk) disable iff (!xrst)
    state == S_IDLE |-> !pix_valid
  );

  a_no_wr_busy: assert property (
    @(posedge clk) disable iff (!xrst)
    busy |-> !wr_we
  );

endmodule

// File: rtl/window_buffer.sv
module window_buffer
  import renkon_num_pkg::*;
#(
  parameter int IMG_WIDTH = 8
) (
  input  logic    clk,
  input  logic    xrst,
  input  logic    pix_valid,
  input  data_t   pixel,
  output window_t window
);

  localparam int NLINE = KSIZE - 1;
  localparam int CW    = $clog2(IMG_WIDTH);

  data_t          line_mem [NLINE][IMG_WIDTH];  // line 0 is the oldest row.
  data_t          rd_col [NLINE];
  logic  [CW-1:0] col;
  window_t        r_window;

  // column pointer, wraps each row.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      col <= '0;
    end else if (pix_valid) begin
      if (col == CW'(IMG_WIDTH - 1)) begin
        col <= '0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NLINE; k++) begin
      rd_col[k] = line_mem[k][col];
    end
  end

  // ********************
  // line buffers
  // ********************
  // each line moves up by one row at the current column.
  always_ff @(posedge clk) begin
    if (pix_valid) begin
      for (int k = 0; k < NLINE - 1; k++) begin
        line_mem[k][col] <= rd_col[k+1];
      end
      line_mem[NLINE-1][col] <= pixel;
    end
  end

  // ********************
  // 5x5 window
  // ********************
  always_ff @(posedge clk) begin
    if (pix_valid) begin
      for (int r = 0; r < KSIZE; r++) begin
        for (int c = 0; c < KSIZE - 1; c++) begin
          r_window[r*KSIZE+c] <= r_window[r*KSIZE+c+1];  // shift left.
        end
      end
      for (int r = 0; r < NLINE; r++) begin
        r_window[r*KSIZE+KSIZE-1] <= rd_col[r];
      end
      r_window[KTAPS-1] <= pixel;  // newest row, newest column.
    end
  end

  assign window = r_window;

endmodule

// File: rtl/weight_bank.sv
module weight_bank
  import renkon_num_pkg::*;
  import renkon_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  wr_t     wr,
  output window_t weights,
  output data_t   bias
);

  window_t r_weights;
  data_t   r_bias;

  // one word per strobe, the bias sits above the taps.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_weights <= '0;
      r_bias    <= '0;
    end else if (wr.we) begin
      if (wr.addr == BIAS_ADDR) begin
        r_bias <= wr.data;
      end else begin
        r_weights[wr.addr] <= wr.data;
      end
    end
  end

  assign weights = r_weights;
  assign bias    = r_bias;

  // writes outside the tap and bias range would be lost.
  a_wr_addr: assert property (
    @(posedge clk) disable iff (!xrst)
    wr.we |-> wr.addr <= BIAS_ADDR
  );

endmodule

// File: rtl/conv_tree25.sv
module conv_tree25
  import renkon_num_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  window_t pixel,
  input  window_t weight,
  output data_t   fmap
);

  window_t r_pixel;
  window_t r_weight;
  prod_t   r_pro [KTAPS];
  data_t   r_pro_short [KTAPS];
  data_t   r_pro_short24_d1;

  data_t   sum0 [12];
  data_t   sum1 [6];
  data_t   sum2 [3];
  data_t   r_sum2 [3];
  data_t   sum3 [2];
  data_t   sum4;
  data_t   r_fmap;

  // ********************
  // stage 1 to 3, products
  // ********************
  always_ff @(posedge clk) begin
    r_pixel  <= pixel;
    r_weight <= weight;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < KTAPS; i++) begin
      r_pro[i] <= r_pixel[i] * r_weight[i];  // full width signed.
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < KTAPS; i++) begin
      r_pro_short[i] <= round_prod(r_pro[i]);
    end
  end

  // ********************
  // stage 4, partial sums
  // ********************
  // 24 products fold to three partial sums, all sums wrap at DWIDTH.
  always_comb begin
    for (int i = 0; i < 12; i++) begin
      sum0[i] = r_pro_short[2*i] + r_pro_short[2*i+1];
    end
    for (int i = 0; i < 6; i++) begin
      sum1[i] = sum0[2*i] + sum0[2*i+1];
    end
    for (int i = 0; i < 3; i++) begin
      sum2[i] = sum1[2*i] + sum1[2*i+1];
    end
  end

  always_ff @(posedge clk) begin
    r_sum2           <= sum2;
    r_pro_short24_d1 <= r_pro_short[KTAPS-1];  // odd tap waits for level 3.
  end

  // ********************
  // stage 5, final sum
  // ********************
  always_comb begin
    sum3[0] = r_sum2[0] + r_sum2[1];
    sum3[1] = r_sum2[2] + r_pro_short24_d1;
    sum4    = sum3[0] + sum3[1];
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fmap <= '0;
    end else begin
      r_fmap <= sum4;
    end
  end

  assign fmap = r_fmap;

endmodule

// File: rtl/renkon_ctrl_pkg.sv
package renkon_ctrl_pkg;
  import renkon_num_pkg::*;

  localparam int AWIDTH = 5;
  localparam logic [AWIDTH-1:0] BIAS_ADDR = AWIDTH'(KTAPS);  // taps sit below it.

  // ********************
  // layer control
  // ********************
  typedef enum logic [1:0] {
    S_IDLE,  // waiting for start.
    S_FILL,  // first rows, no full window yet.
    S_RUN,   // windows complete.
    S_DONE   // pipeline drain.
  } conv_state_e;

  // weight or bias write.
  typedef struct packed {
    logic              we;
    logic [AWIDTH-1:0] addr;
    data_t             data;
  } wr_t;

  // one output pixel.
  typedef struct packed {
    logic  valid;
    logic  last;
    data_t data;
  } fmap_t;

endpackage

// File: rtl/renkon_num_pkg.sv
package renkon_num_pkg;

  // ********************
  // fixed point format
  // ********************
  localparam int DWIDTH = 16;
  localparam int FRAC   = DWIDTH / 2;  // q8.8.

  localparam int KSIZE = 5;
  localparam int KTAPS = KSIZE * KSIZE;

  typedef logic signed [DWIDTH-1:0]   data_t;
  typedef logic signed [2*DWIDTH-1:0] prod_t;

  // tap index is row * KSIZE + col, row 0 oldest.
  typedef data_t [KTAPS-1:0] window_t;

  `include "renkon.svh"

endpackage

// File: include/renkon.svh
`ifndef RENKON_SVH
`define RENKON_SVH

// narrows a double-width product to the data format.
// the word keeps bits FRAC up to the top kept bit, sign extended from it.
// an exact negative product with a zero fraction drops by one lsb.
function automatic data_t round_prod(input prod_t prod);
  logic [DWIDTH-1:0] kept;
  kept = {prod[2*DWIDTH-FRAC-2], prod[2*DWIDTH-FRAC-2:FRAC]};
  if (prod[2*DWIDTH-FRAC-2] && prod[FRAC-1:0] == '0) begin
    kept = kept - 1'b1;
  end
  return data_t'(kept);
endfunction

`endif
